/* project.f */
frontend_pkg.sv
fetch_ctrl.sv
branch_predecoder.sv
inst_buffer.sv
frontend_top.sv
tb_imem_model.sv
tb_frontend.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_frontend
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_frontend.sv */
module tb_frontend;
    import frontend_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int TEST_CYCLES = 5000;
    localparam int KIND_PLAIN  = 0;
    localparam int KIND_JAL    = 1;
    localparam int KIND_BRANCH = 2;
    localparam int KIND_JALR   = 3;

    logic            clk;
    logic            arst_n_i;
    logic            imem_req_ready;
    logic            imem_resp_valid;
    logic [XLEN-1:0] imem_resp_inst;
    logic            flush_i;
    logic [XLEN-1:0] redirect_pc_i;
    logic            issue0_ready_i;
    logic            issue1_ready_i;
    logic            imem_req_valid;
    logic [XLEN-1:0] imem_req_addr;
    logic            issue0_valid_o;
    logic            issue1_valid_o;
    logic [XLEN-1:0] issue0_pc_o;
    logic [XLEN-1:0] issue1_pc_o;
    logic [XLEN-1:0] issue0_inst_o;
    logic [XLEN-1:0] issue1_inst_o;
    logic            issue0_is_branch_o;
    logic            issue1_is_branch_o;
    logic            issue0_pred_taken_o;
    logic            issue1_pred_taken_o;
    logic [XLEN-1:0] issue0_pred_target_o;
    logic [XLEN-1:0] issue1_pred_target_o;
    logic            imem_busy;
    logic [1:0]      imem_wait;

    // Reference program, one kind and offset per memory word
    int              kind_tab [1024];
    int              off_tab  [1024];
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] hold_pc;
    logic            hold_chk;
    logic            flush_seen;
    integer          seed;
    integer          rnd;
    int              issued_cnt;
    int              resp_cnt;
    int              dual_cnt;
    int              lone1_cnt;
    int              branch_cnt;
    int              errors;
    int              tests_run;
    int              tests_failed;

    frontend_top DUT (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .imem_req_ready_i(imem_req_ready),
        .imem_resp_valid_i(imem_resp_valid),
        .imem_resp_inst_i(imem_resp_inst),
        .flush_i(flush_i),
        .redirect_pc_i(redirect_pc_i),
        .issue0_ready_i(issue0_ready_i),
        .issue1_ready_i(issue1_ready_i),
        .imem_req_valid_o(imem_req_valid),
        .imem_req_addr_o(imem_req_addr),
        .issue0_valid_o(issue0_valid_o),
        .issue0_pc_o(issue0_pc_o),
        .issue0_inst_o(issue0_inst_o),
        .issue0_is_branch_o(issue0_is_branch_o),
        .issue0_pred_taken_o(issue0_pred_taken_o),
        .issue0_pred_target_o(issue0_pred_target_o),
        .issue1_valid_o(issue1_valid_o),
        .issue1_pc_o(issue1_pc_o),
        .issue1_inst_o(issue1_inst_o),
        .issue1_is_branch_o(issue1_is_branch_o),
        .issue1_pred_taken_o(issue1_pred_taken_o),
        .issue1_pred_target_o(issue1_pred_target_o)
    );

    tb_imem_model u_imem (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .req_valid_i(imem_req_valid),
        .req_addr_i(imem_req_addr),
        .req_ready_o(imem_req_ready),
        .resp_valid_o(imem_resp_valid),
        .resp_inst_o(imem_resp_inst),
        .busy_o(imem_busy),
        .wait_o(imem_wait)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired, the run took longer than the tests allow");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and reporting helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        // ADDI x1 with an immediate folded from every address bit
        return {addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0}, 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [XLEN-1:0] next_pc_ref(input logic [XLEN-1:0] pc);
        int k;
        int o;
        k = kind_tab[pc[11:2]];
        o = off_tab[pc[11:2]];
        if (k == KIND_JAL || (k == KIND_BRANCH && o < 0)) begin
            return pc + o;
        end
        return pc + 32'd4;
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic check_slot(input int slot, input logic [XLEN-1:0] pc,
                              input logic [XLEN-1:0] inst, input logic isb,
                              input logic tk, input logic [XLEN-1:0] tgt);
        int k;
        int o;
        k = kind_tab[exp_pc[11:2]];
        o = off_tab[exp_pc[11:2]];
        compare_value($sformatf("issue%0d_pc_o", slot), pc, exp_pc);
        compare_value($sformatf("issue%0d_inst_o", slot), inst, u_imem.mem[exp_pc[11:2]]);
        compare_value($sformatf("issue%0d_is_branch_o", slot), 32'(isb),
                      32'(k != KIND_PLAIN));
        compare_value($sformatf("issue%0d_pred_taken_o", slot), 32'(tk),
                      32'(k == KIND_JAL || (k == KIND_BRANCH && o < 0)));
        if (k == KIND_JAL || k == KIND_BRANCH) begin
            compare_value($sformatf("issue%0d_pred_target_o", slot), tgt, exp_pc + o);
        end
        if (k != KIND_PLAIN) begin
            branch_cnt++;
        end
        exp_pc = next_pc_ref(exp_pc);
        issued_cnt++;
    endtask

    ////////////////////////////////////////////////////////////
    // Decode-side monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!arst_n_i) begin
            exp_pc     = RESET_PC;
            hold_chk   = 1'b0;
            flush_seen = 1'b0;
            issued_cnt = 0;
            resp_cnt   = 0;
        end else begin
            if (issue1_valid_o && !issue0_valid_o) begin
                report_error("issue1_valid_o is high while issue0_valid_o is low");
            end
            if (flush_seen && issue0_valid_o) begin
                report_error("buffer still holds entries in the cycle after a flush");
            end
            if (hold_chk) begin
                compare_value("issue0_valid_o", 32'(issue0_valid_o), 32'd1);
                compare_value("issue0_pc_o", issue0_pc_o, hold_pc);
            end
            hold_chk   = 1'b0;
            flush_seen = 1'b0;
            if (imem_resp_valid) begin
                resp_cnt++;
            end
            if (flush_i) begin
                exp_pc     = redirect_pc_i;
                flush_seen = 1'b1;
            end else begin
                if (issue0_valid_o && issue1_valid_o) begin
                    compare_value("issue1_pc_o", issue1_pc_o, next_pc_ref(exp_pc));
                end
                if (issue0_valid_o && issue0_ready_i) begin
                    check_slot(0, issue0_pc_o, issue0_inst_o, issue0_is_branch_o,
                               issue0_pred_taken_o, issue0_pred_target_o);
                    if (issue1_valid_o && issue1_ready_i) begin
                        check_slot(1, issue1_pc_o, issue1_inst_o, issue1_is_branch_o,
                                   issue1_pred_taken_o, issue1_pred_target_o);
                        dual_cnt++;
                    end
                end else if (issue0_valid_o) begin
                    // Slot 0 stalls, so nothing may move
                    hold_chk = 1'b1;
                    hold_pc  = issue0_pc_o;
                    if (issue1_valid_o && issue1_ready_i) begin
                        lone1_cnt++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic load_plain();
        for (int i = 0; i < 1024; i++) begin
            u_imem.mem[i] = fill_word(32'h0000_1000 + 32'(i * 4));
            kind_tab[i]   = KIND_PLAIN;
            off_tab[i]    = 0;
        end
    endtask

    task automatic place_entry(input logic [XLEN-1:0] addr, input int kind, input int off);
        logic [31:0] o;
        logic [31:0] w;
        o = off;
        if (kind == KIND_JAL) begin
            w = {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
        end else if (kind == KIND_BRANCH) begin
            w = {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], 7'b1100011};
        end else begin
            w = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
        end
        u_imem.mem[addr[11:2]] = w;
        kind_tab[addr[11:2]]   = kind;
        off_tab[addr[11:2]]    = off;
    endtask

    task automatic set_readies(input logic r0, input logic r1);
        @(posedge clk);
        issue0_ready_i <= r0;
        issue1_ready_i <= r1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n_i       <= 1'b0;
        flush_i        <= 1'b0;
        issue0_ready_i <= 1'b0;
        issue1_ready_i <= 1'b0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (imem_req_valid || issue0_valid_o || issue1_valid_o) begin
            report_error("request or issue valid is high during reset");
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compare_value("imem_req_valid_o", 32'(imem_req_valid), 32'd1);
        compare_value("imem_req_addr_o", imem_req_addr, RESET_PC);
    endtask

    task automatic wait_issued(input int target, input int limit, input logic random_ready,
                               input string name);
        int n;
        n = 0;
        while (issued_cnt < target && n < limit) begin
            @(posedge clk);
            if (random_ready) begin
                rnd = $random(seed);
                issue0_ready_i <= rnd[0];
                issue1_ready_i <= rnd[1];
            end
            n++;
        end
        if (issued_cnt < target) begin
            report_error($sformatf("%s timed out waiting for %0d issued entries", name, target));
        end
    endtask

    task automatic flush_to(input logic [XLEN-1:0] addr);
        @(posedge clk);
        flush_i        <= 1'b1;
        redirect_pc_i  <= addr;
        issue0_ready_i <= 1'b0;
        issue1_ready_i <= 1'b0;
        @(posedge clk);
        flush_i        <= 1'b0;
        issue0_ready_i <= 1'b1;
        issue1_ready_i <= 1'b1;
    endtask

    task automatic finish_test(input string name, input int base_err);
        tests_run++;
        if (errors == base_err) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errors - base_err);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_sequential();
        int base_err;
        base_err = errors;
        load_plain();
        apply_reset();
        set_readies(1'b1, 1'b1);
        wait_issued(40, 400, 1'b0, "sequential");
        finish_test("sequential stream", base_err);
    endtask

    task automatic test_backpressure();
        int base_err;
        int n;
        base_err = errors;
        load_plain();
        apply_reset();
        n = 0;
        while (resp_cnt < IBUF_DEPTH && n < 400) begin
            @(negedge clk);
            n++;
        end
        repeat (40) begin
            @(negedge clk);
            if (imem_req_valid) begin
                report_error("fetch request raised while the buffer is full");
            end
        end
        compare_value("responses while stalled", 32'(resp_cnt), 32'(IBUF_DEPTH));
        // Full buffer still shows the first fetched word at its head
        compare_value("issue1_valid_o", 32'(issue1_valid_o), 32'd1);
        compare_value("issue0_pc_o", issue0_pc_o, RESET_PC);
        wait_issued(60, 800, 1'b1, "backpressure");
        finish_test("back-pressure", base_err);
    endtask

    task automatic test_dual_issue();
        int base_err;
        base_err  = errors;
        dual_cnt  = 0;
        lone1_cnt = 0;
        load_plain();
        apply_reset();
        wait_issued(80, 800, 1'b1, "dual issue");
        if (dual_cnt == 0 || lone1_cnt == 0) begin
            report_error("dual issue and lone slot 1 ready cases were not both seen");
        end
        finish_test("dual issue", base_err);
    endtask

    task automatic test_prediction();
        int base_err;
        base_err   = errors;
        branch_cnt = 0;
        load_plain();
        place_entry(32'h0000_1004, KIND_JAL, 32'h20);
        place_entry(32'h0000_1028, KIND_BRANCH, 32'h40);
        place_entry(32'h0000_102c, KIND_JALR, 0);
        place_entry(32'h0000_1040, KIND_BRANCH, -32'h38);
        apply_reset();
        set_readies(1'b1, 1'b1);
        wait_issued(60, 600, 1'b0, "prediction");
        if (branch_cnt < 4) begin
            report_error("too few control-transfer entries were issued");
        end
        finish_test("static prediction", base_err);
    endtask

    task automatic test_flush();
        int base_err;
        int n;
        int quiet;
        base_err = errors;
        load_plain();
        apply_reset();
        set_readies(1'b1, 1'b1);
        wait_issued(10, 400, 1'b0, "flush warm-up");
        // Response still at least a cycle away when the flush lands
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(imem_busy && imem_wait != 2'd0) && n < 400);
        if (n >= 400) begin
            report_error("no pending memory response found to flush against");
        end
        flush_to(32'h0000_1800);
        wait_issued(issued_cnt + 10, 400, 1'b0, "flush pending");
        // Let fetch stop on a full buffer, then flush with nothing in flight
        set_readies(1'b0, 1'b0);
        n     = 0;
        quiet = 0;
        while (quiet < 3 && n < 400) begin
            @(negedge clk);
            quiet = (!imem_req_valid && !imem_busy) ? quiet + 1 : 0;
            n++;
        end
        flush_to(32'h0000_1400);
        wait_issued(issued_cnt + 10, 400, 1'b0, "flush idle");
        finish_test("flush and redirect", base_err);
    endtask

    initial begin
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        redirect_pc_i  = '0;
        issue0_ready_i = 1'b0;
        issue1_ready_i = 1'b0;
        seed           = 32'h7a10;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_sequential();
        test_backpressure();
        test_dual_issue();
        test_prediction();
        test_flush();
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb_imem_model.sv */
module tb_imem_model (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         req_valid_i,
    input  logic [frontend_pkg::XLEN-1:0] req_addr_i,
    output logic                         req_ready_o,
    output logic                         resp_valid_o,
    output logic [frontend_pkg::XLEN-1:0] resp_inst_o,
    output logic                         busy_o,
    output logic [1:0]                   wait_o
);
    import frontend_pkg::*;

    localparam int MEM_WORDS = 1024;

    // Word array, indexed by address bits 11:2
    logic [XLEN-1:0] mem [MEM_WORDS];

    integer          seed;
    integer          rnd;
    logic            pending_q;
    logic [1:0]      wait_q;
    logic [XLEN-1:0] addr_q;

    initial seed = 32'h7a10;

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_ready_o  <= 1'b0;
            resp_valid_o <= 1'b0;
            resp_inst_o  <= '0;
            pending_q    <= 1'b0;
            wait_q       <= 2'd0;
            addr_q       <= '0;
        end else begin
            rnd = $random(seed);
            // Ready drops on roughly a quarter of the cycles
            req_ready_o  <= (rnd[1:0] != 2'b00);
            resp_valid_o <= 1'b0;
            if (pending_q) begin
                if (wait_q == 2'd0) begin
                    resp_valid_o <= 1'b1;
                    resp_inst_o  <= mem[addr_q[11:2]];
                    pending_q    <= 1'b0;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
            // Delay of 1 to 3 cycles per accepted request
            if (req_valid_i && req_ready_o) begin
                pending_q <= 1'b1;
                addr_q    <= req_addr_i;
                wait_q    <= (rnd[3:2] == 2'd3) ? 2'd2 : rnd[3:2];
            end
        end
    end

    assign busy_o = pending_q;
    assign wait_o = wait_q;

endmodule

/* frontend_top.sv */
module frontend_top (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         imem_req_ready_i,
    input  logic                         imem_resp_valid_i,
    input  logic [frontend_pkg::XLEN-1:0] imem_resp_inst_i,
    input  logic                         flush_i,
    input  logic [frontend_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                         issue0_ready_i,
    input  logic                         issue1_ready_i,
    output logic                         imem_req_valid_o,
    output logic [frontend_pkg::XLEN-1:0] imem_req_addr_o,
    output logic                         issue0_valid_o,
    output logic [frontend_pkg::XLEN-1:0] issue0_pc_o,
    output logic [frontend_pkg::XLEN-1:0] issue0_inst_o,
    output logic                         issue0_is_branch_o,
    output logic                         issue0_pred_taken_o,
    output logic [frontend_pkg::XLEN-1:0] issue0_pred_target_o,
    output logic                         issue1_valid_o,
    output logic [frontend_pkg::XLEN-1:0] issue1_pc_o,
    output logic [frontend_pkg::XLEN-1:0] issue1_inst_o,
    output logic                         issue1_is_branch_o,
    output logic                         issue1_pred_taken_o,
    output logic [frontend_pkg::XLEN-1:0] issue1_pred_target_o
);
    import frontend_pkg::*;

    // Fetch to predecoder and buffer
    logic [XLEN-1:0]    fetch_pc;
    logic [XLEN-1:0]    fetch_inst;
    logic               wr_valid;
    logic               is_branch;
    logic               pred_taken;
    logic [XLEN-1:0]    pred_target;
    logic [IBUF_CW-1:0] buf_count;

    fetch_ctrl u_fetch_ctrl (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .imem_req_ready_i  (imem_req_ready_i),
        .imem_resp_valid_i (imem_resp_valid_i),
        .imem_resp_inst_i  (imem_resp_inst_i),
        .flush_i           (flush_i),
        .redirect_pc_i     (redirect_pc_i),
        .pred_taken_i      (pred_taken),
        .pred_target_i     (pred_target),
        .buf_count_i       (buf_count),
        .imem_req_valid_o  (imem_req_valid_o),
        .imem_req_addr_o   (imem_req_addr_o),
        .fetch_pc_o        (fetch_pc),
        .fetch_inst_o      (fetch_inst),
        .wr_valid_o        (wr_valid)
    );

    branch_predecoder u_predecoder (
        .pc_i          (fetch_pc),
        .inst_i        (fetch_inst),
        .is_branch_o   (is_branch),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    inst_buffer u_inst_buffer (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .flush_i              (flush_i),
        .wr_valid_i           (wr_valid),
        .wr_pc_i              (fetch_pc),
        .wr_inst_i            (fetch_inst),
        .wr_is_branch_i       (is_branch),
        .wr_pred_taken_i      (pred_taken),
        .wr_pred_target_i     (pred_target),
        .issue0_ready_i       (issue0_ready_i),
        .issue1_ready_i       (issue1_ready_i),
        .count_o              (buf_count),
        .issue0_valid_o       (issue0_valid_o),
        .issue0_pc_o          (issue0_pc_o),
        .issue0_inst_o        (issue0_inst_o),
        .issue0_is_branch_o   (issue0_is_branch_o),
        .issue0_pred_taken_o  (issue0_pred_taken_o),
        .issue0_pred_target_o (issue0_pred_target_o),
        .issue1_valid_o       (issue1_valid_o),
        .issue1_pc_o          (issue1_pc_o),
        .issue1_inst_o        (issue1_inst_o),
        .issue1_is_branch_o   (issue1_is_branch_o),
        .issue1_pred_taken_o  (issue1_pred_taken_o),
        .issue1_pred_target_o (issue1_pred_target_o)
    );

endmodule

/* inst_buffer.sv */
module inst_buffer (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             flush_i,
    input  logic                             wr_valid_i,
    input  logic [frontend_pkg::XLEN-1:0]    wr_pc_i,
    input  logic [frontend_pkg::XLEN-1:0]    wr_inst_i,
    input  logic                             wr_is_branch_i,
    input  logic                             wr_pred_taken_i,
    input  logic [frontend_pkg::XLEN-1:0]    wr_pred_target_i,
    input  logic                             issue0_ready_i,
    input  logic                             issue1_ready_i,
    output logic [frontend_pkg::IBUF_CW-1:0] count_o,
    output logic                             issue0_valid_o,
    output logic [frontend_pkg::XLEN-1:0]    issue0_pc_o,
    output logic [frontend_pkg::XLEN-1:0]    issue0_inst_o,
    output logic                             issue0_is_branch_o,
    output logic                             issue0_pred_taken_o,
    output logic [frontend_pkg::XLEN-1:0]    issue0_pred_target_o,
    output logic                             issue1_valid_o,
    output logic [frontend_pkg::XLEN-1:0]    issue1_pc_o,
    output logic [frontend_pkg::XLEN-1:0]    issue1_inst_o,
    output logic                             issue1_is_branch_o,
    output logic                             issue1_pred_taken_o,
    output logic [frontend_pkg::XLEN-1:0]    issue1_pred_target_o
);
    import frontend_pkg::*;

    ////////////////////////////////////////////////////////////
    // Entry storage, one array per field
    ////////////////////////////////////////////////////////////

    logic [XLEN-1:0] pc_mem     [IBUF_DEPTH];
    logic [XLEN-1:0] inst_mem   [IBUF_DEPTH];
    logic            branch_mem [IBUF_DEPTH];
    logic            taken_mem  [IBUF_DEPTH];
    logic [XLEN-1:0] target_mem [IBUF_DEPTH];

    logic [IBUF_AW-1:0] head_q;
    logic [IBUF_AW-1:0] tail_q;
    logic [IBUF_CW-1:0] count_q;

    logic [IBUF_AW-1:0] head_next_idx;
    logic               wr_en;
    logic               pop0;
    logic               pop1;
    logic [1:0]         pop_n;

    // Writes during a flush belong to the old stream
    assign wr_en = wr_valid_i && !flush_i;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[tail_q]     <= wr_pc_i;
            inst_mem[tail_q]   <= wr_inst_i;
            branch_mem[tail_q] <= wr_is_branch_i;
            taken_mem[tail_q]  <= wr_pred_taken_i;
            target_mem[tail_q] <= wr_pred_target_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue slots
    ////////////////////////////////////////////////////////////

    // Index wraps naturally at IBUF_DEPTH
    assign head_next_idx = head_q + IBUF_AW'(1);

    assign issue0_valid_o = (count_q != '0);
    assign issue1_valid_o = (count_q >= IBUF_CW'(2));

    // Show-ahead, slot 0 is the oldest entry
    assign issue0_pc_o          = pc_mem[head_q];
    assign issue0_inst_o        = inst_mem[head_q];
    assign issue0_is_branch_o   = branch_mem[head_q];
    assign issue0_pred_taken_o  = taken_mem[head_q];
    assign issue0_pred_target_o = target_mem[head_q];

    assign issue1_pc_o          = pc_mem[head_next_idx];
    assign issue1_inst_o        = inst_mem[head_next_idx];
    assign issue1_is_branch_o   = branch_mem[head_next_idx];
    assign issue1_pred_taken_o  = taken_mem[head_next_idx];
    assign issue1_pred_target_o = target_mem[head_next_idx];

    // Slot 1 only leaves together with slot 0, keeps program order
    assign pop0  = issue0_valid_o && issue0_ready_i;
    assign pop1  = pop0 && issue1_valid_o && issue1_ready_i;
    assign pop_n = {1'b0, pop0} + {1'b0, pop1};

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + IBUF_AW'(pop_n);
            tail_q  <= tail_q + IBUF_AW'(wr_en);
            count_q <= count_q + IBUF_CW'(wr_en) - IBUF_CW'(pop_n);
        end
    end

    assign count_o = count_q;

endmodule

/* branch_predecoder.sv */
module branch_predecoder (
    input  logic [frontend_pkg::XLEN-1:0] pc_i,
    input  logic [frontend_pkg::XLEN-1:0] inst_i,
    output logic                         is_branch_o,
    output logic                         pred_taken_o,
    output logic [frontend_pkg::XLEN-1:0] pred_target_o
);
    import frontend_pkg::*;

    logic [6:0]      opcode;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    logic            is_jal;
    logic            is_jalr;
    logic            is_cond;

    ////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////

    assign opcode = inst_i[6:0];

    // J-type, imm[20|10:1|11|19:12]
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // B-type, imm[12|10:5] and imm[4:1|11]
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    assign is_jal  = (opcode == OPC_JAL);
    assign is_jalr = (opcode == OPC_JALR);
    assign is_cond = (opcode == OPC_BRANCH);

    ////////////////////////////////////////////////////////////
    // Static prediction
    ////////////////////////////////////////////////////////////

    assign is_branch_o = is_jal || is_jalr || is_cond;

    // Backward branches are loops, sign bit of the offset says so
    assign pred_taken_o = is_jal || (is_cond && inst_i[31]);

    // JALR needs a register value, never predicted
    assign pred_target_o = pc_i + (is_jal ? imm_j : imm_b);

endmodule

/* fetch_ctrl.sv */
module fetch_ctrl (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         imem_req_ready_i,
    input  logic                         imem_resp_valid_i,
    input  logic [frontend_pkg::XLEN-1:0] imem_resp_inst_i,
    input  logic                         flush_i,
    input  logic [frontend_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                         pred_taken_i,
    input  logic [frontend_pkg::XLEN-1:0] pred_target_i,
    input  logic [frontend_pkg::IBUF_CW-1:0] buf_count_i,
    output logic                         imem_req_valid_o,
    output logic [frontend_pkg::XLEN-1:0] imem_req_addr_o,
    output logic [frontend_pkg::XLEN-1:0] fetch_pc_o,
    output logic [frontend_pkg::XLEN-1:0] fetch_inst_o,
    output logic                         wr_valid_o
);
    import frontend_pkg::*;

    logic            req_valid_q;
    logic [XLEN-1:0] req_addr_q;
    logic            outstanding_q;
    logic            stale_q;
    logic [XLEN-1:0] next_pc_q;

    logic               req_fire;
    logic               resp_live;
    logic               busy_next;
    logic               can_fetch;
    logic               stale_set;
    logic [XLEN-1:0]    next_pc_d;
    logic [IBUF_CW-1:0] occupancy;

    assign req_fire = req_valid_q && imem_req_ready_i;

    // A flush in the response cycle wins and the word is dropped
    assign resp_live = imem_resp_valid_i && outstanding_q && !stale_q && !flush_i;

    // Still waiting on memory after this edge
    assign busy_next = outstanding_q ? !imem_resp_valid_i : req_fire;

    // Count the word being written now as already in the buffer
    assign occupancy = buf_count_i + {{(IBUF_CW-1){1'b0}}, wr_valid_o};
    assign can_fetch = flush_i || (occupancy < IBUF_CW'(IBUF_DEPTH));

    // Anything already on the bus or in memory at a flush is stale
    assign stale_set = flush_i && (req_valid_q || (outstanding_q && !imem_resp_valid_i));

    always_comb begin
        if (flush_i) begin
            next_pc_d = redirect_pc_i;
        end else if (resp_live) begin
            next_pc_d = pred_taken_i ? pred_target_i : req_addr_q + XLEN'(4);
        end else begin
            next_pc_d = next_pc_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_q   <= 1'b0;
            req_addr_q    <= RESET_PC;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
            next_pc_q     <= RESET_PC;
        end else begin
            outstanding_q <= busy_next;
            next_pc_q     <= next_pc_d;

            if (stale_set) begin
                stale_q <= 1'b1;
            end else if (imem_resp_valid_i) begin
                stale_q <= 1'b0;
            end

            // Held request keeps valid and address until accepted
            if (req_valid_q && !imem_req_ready_i) begin
                req_valid_q <= 1'b1;
            end else if (!busy_next && can_fetch) begin
                req_valid_q <= 1'b1;
                req_addr_q  <= next_pc_d;
            end else begin
                req_valid_q <= 1'b0;
            end
        end
    end

    assign imem_req_valid_o = req_valid_q;
    assign imem_req_addr_o  = req_addr_q;

    // Address stays put while in flight, so it tags the response
    assign fetch_pc_o   = req_addr_q;
    assign fetch_inst_o = imem_resp_inst_i;
    assign wr_valid_o   = resp_live;

endmodule

/* frontend_pkg.sv */
package frontend_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    // Instruction word and address width
    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////
    // Instruction buffer geometry
    ////////////////////////////////////////////////////////////

    // Number of entries
    localparam int IBUF_DEPTH = 16;

    // Head and tail index width
    localparam int IBUF_AW = 4;

    // Occupancy counter, must reach IBUF_DEPTH itself
    localparam int IBUF_CW = 5;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    // First fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    ////////////////////////////////////////////////////////////
    // RV32I major opcodes seen by the predecoder
    ////////////////////////////////////////////////////////////

    // Unconditional jump, J-type immediate
    localparam logic [6:0] OPC_JAL = 7'b110_1111;

    // Register indirect jump, target unknown at fetch
    localparam logic [6:0] OPC_JALR = 7'b110_0111;

    // Conditional branch, B-type immediate
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

endpackage
